//--- rtl/masku_lane_pkg.sv
package masku_lane_pkg;

  // Number of lanes in the vector unit
  localparam int unsigned NrLanes = 4;

  // Lane datapath width
  localparam int unsigned ElenW = 64;

  // Bytes in one lane word
  localparam int unsigned StrbW = ElenW / 8;

  // Destination bits covered by one beat over all lanes
  localparam int unsigned BeatBits = NrLanes * ElenW;

  // Result entries held before back-pressure reaches the operands
  localparam int unsigned ResultQueueDepth = 2;

  // One lane data word
  typedef logic [ElenW-1:0] elen_t;

  // Byte strobe of one lane word
  typedef logic [StrbW-1:0] strb_t;

  // Register file word address
  typedef logic [7:0] vaddr_t;

  // One flag per lane, used for valid, ready, request and grant
  typedef logic [NrLanes-1:0] lane_bits_t;

endpackage

//--- rtl/masku_insn_pkg.sv
package masku_insn_pkg;

  // Number of distinct instruction ids
  localparam int unsigned NrVInsn = 8;

  // Vector length width, enough for vl up to 2048
  localparam int unsigned VlW = 12;

  // Instruction id
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  // Vector length, also used as a bit or beat count
  typedef logic [VlW-1:0] vlen_t;

  // One done flag per instruction id
  typedef logic [NrVInsn-1:0] insn_done_t;

  // Issue controller states
  // IDLE waits for an instruction
  // ISSUE fires beats while operands arrive
  // DRAIN waits for the queued beats to be written back
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    DRAIN
  } issue_state_e;

endpackage

//--- rtl/masku_merge_alu.sv
`timescale 1ns/1ps

module masku_merge_alu (
  // Instruction state of the current beat
  input  masku_lane_pkg::vaddr_t                                vd_i,
  input  logic                                                  vm_i,
  input  masku_insn_pkg::vlen_t                                 vl_i,
  input  masku_lane_pkg::vaddr_t                                beat_idx_i,
  // Lane operands
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]   operand_a_i,
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]   operand_b_i,
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]   operand_m_i,
  // Merged result of the beat
  output masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]   wdata_o,
  output masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0]   be_o,
  output masku_lane_pkg::vaddr_t                                addr_o
);

  // Positions of this beat below the remaining bit count
  logic [masku_lane_pkg::BeatBits-1:0] vl_en;

  // Final per-bit select, a where set and b elsewhere
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] bit_en;

  // vl_i already has the earlier beats taken off
  // so position p of this beat is global bit k*256 + p
  always_comb begin
    for (int unsigned p = 0; p < masku_lane_pkg::BeatBits; p++) begin
      vl_en[p] = (p < vl_i);
    end
  end

  for (genvar l = 0; l < masku_lane_pkg::NrLanes; l++) begin : gen_lane
    // Mask bit j of lane l gates destination bit j of lane l
    // An unmasked instruction forces the mask to all ones
    assign bit_en[l] = vl_en[l*masku_lane_pkg::ElenW +: masku_lane_pkg::ElenW] &
                       (operand_m_i[l] | {masku_lane_pkg::ElenW{vm_i}});

    // Bitwise merge of the ALU result and the old destination value
    assign wdata_o[l] = (operand_a_i[l] & bit_en[l]) | (operand_b_i[l] & ~bit_en[l]);

    // Byte written when its first bit lies below vl, mask does not matter here
    for (genvar n = 0; n < masku_lane_pkg::StrbW; n++) begin : gen_byte
      assign be_o[l][n] = vl_en[l*masku_lane_pkg::ElenW + 8*n];
    end
  end

  // One register file word per lane per beat
  assign addr_o = vd_i + beat_idx_i;

endmodule

//--- rtl/masku_issue_ctrl.sv
`timescale 1ns/1ps

module masku_issue_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Instruction from the sequencer
  input  masku_insn_pkg::vid_t         pe_req_id_i,
  input  masku_lane_pkg::vaddr_t       pe_req_vd_i,
  input  masku_insn_pkg::vlen_t        pe_req_vl_i,
  input  logic                         pe_req_vm_i,
  input  logic                         pe_req_valid_i,
  output logic                         pe_req_ready_o,
  // Operand handshake with the lanes
  input  masku_lane_pkg::lane_bits_t   operand_a_valid_i,
  input  masku_lane_pkg::lane_bits_t   operand_b_valid_i,
  input  masku_lane_pkg::lane_bits_t   operand_m_valid_i,
  output masku_lane_pkg::lane_bits_t   operand_a_ready_o,
  output masku_lane_pkg::lane_bits_t   operand_b_ready_o,
  output masku_lane_pkg::lane_bits_t   operand_m_ready_o,
  // Result queue status
  input  logic                         queue_full_i,
  input  logic                         retire_i,
  // Beat control towards the merge ALU and the result queue
  output logic                         beat_fire_o,
  output masku_lane_pkg::vaddr_t       beat_idx_o,
  output masku_lane_pkg::vaddr_t       vd_o,
  output logic                         vm_o,
  output masku_insn_pkg::vlen_t        vl_o,
  output masku_insn_pkg::vid_t         id_o,
  // Completion
  output masku_insn_pkg::insn_done_t   vinsn_done_o
);

  masku_insn_pkg::issue_state_e state_q, state_d;

  // Latched instruction, the single entry of the instruction queue
  masku_insn_pkg::vid_t   id_q;
  masku_lane_pkg::vaddr_t vd_q;
  logic                   vm_q;

  // Bits still to be produced, starting at vl
  masku_insn_pkg::vlen_t vl_q, vl_d;
  // Beats still to fire and beats still to retire
  masku_insn_pkg::vlen_t issue_cnt_q, issue_cnt_d;
  masku_insn_pkg::vlen_t commit_cnt_q, commit_cnt_d;
  // Index of the next beat, offsets the destination address
  masku_lane_pkg::vaddr_t beat_idx_q, beat_idx_d;
  masku_insn_pkg::insn_done_t done_q, done_d;

  logic                  accept;
  logic                  operands_valid;
  logic                  fire;
  masku_insn_pkg::vlen_t nr_beats;

  // Only one instruction in flight
  assign pe_req_ready_o = (state_q == masku_insn_pkg::IDLE);
  assign accept         = pe_req_ready_o && pe_req_valid_i;

  // ceil(vl / 256), no overflow since vl is at most 2048
  assign nr_beats = (pe_req_vl_i + masku_insn_pkg::vlen_t'(masku_lane_pkg::BeatBits - 1))
                    >> $clog2(masku_lane_pkg::BeatBits);

  // Mask operand only needed for masked instructions
  assign operands_valid = (&operand_a_valid_i) && (&operand_b_valid_i) &&
                          (vm_q || (&operand_m_valid_i));

  assign fire = (state_q == masku_insn_pkg::ISSUE) && operands_valid && !queue_full_i;

  // All lanes are acknowledged together in the firing cycle
  assign operand_a_ready_o = {masku_lane_pkg::NrLanes{fire}};
  assign operand_b_ready_o = {masku_lane_pkg::NrLanes{fire}};
  assign operand_m_ready_o = {masku_lane_pkg::NrLanes{fire && !vm_q}};

  always_comb begin
    state_d      = state_q;
    vl_d         = vl_q;
    issue_cnt_d  = issue_cnt_q;
    commit_cnt_d = commit_cnt_q;
    beat_idx_d   = beat_idx_q;
    done_d       = '0;

    // A retired beat counts down in ISSUE and DRAIN alike
    if (retire_i) begin
      commit_cnt_d = commit_cnt_q - 1'b1;
    end

    case (state_q)
      masku_insn_pkg::IDLE: begin
        if (accept) begin
          state_d      = masku_insn_pkg::ISSUE;
          vl_d         = pe_req_vl_i;
          issue_cnt_d  = nr_beats;
          commit_cnt_d = nr_beats;
          beat_idx_d   = '0;
        end
      end
      masku_insn_pkg::ISSUE: begin
        if (fire) begin
          issue_cnt_d = issue_cnt_q - 1'b1;
          beat_idx_d  = beat_idx_q + 1'b1;
          // Saturate on the last, partial beat
          if (vl_q > masku_insn_pkg::vlen_t'(masku_lane_pkg::BeatBits)) begin
            vl_d = vl_q - masku_insn_pkg::vlen_t'(masku_lane_pkg::BeatBits);
          end else begin
            vl_d = '0;
          end
          if (issue_cnt_q == masku_insn_pkg::vlen_t'(1)) begin
            state_d = masku_insn_pkg::DRAIN;
          end
        end
      end
      masku_insn_pkg::DRAIN: begin
        // Last beat written on every lane
        if (retire_i && (commit_cnt_q == masku_insn_pkg::vlen_t'(1))) begin
          state_d = masku_insn_pkg::IDLE;
          done_d  = masku_insn_pkg::insn_done_t'(1) << id_q;
        end
      end
      default: state_d = masku_insn_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= masku_insn_pkg::IDLE;
      vl_q         <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      beat_idx_q   <= '0;
      done_q       <= '0;
    end else begin
      state_q      <= state_d;
      vl_q         <= vl_d;
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      beat_idx_q   <= beat_idx_d;
      done_q       <= done_d;
    end
  end

  // Instruction fields held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q <= pe_req_id_i;
      vd_q <= pe_req_vd_i;
      vm_q <= pe_req_vm_i;
    end
  end

  assign beat_fire_o  = fire;
  assign beat_idx_o   = beat_idx_q;
  assign vd_o         = vd_q;
  assign vm_o         = vm_q;
  assign vl_o         = vl_q;
  assign id_o         = id_q;
  assign vinsn_done_o = done_q;

endmodule

//--- rtl/masku_result_queue.sv
`timescale 1ns/1ps

module masku_result_queue (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  // New beat from the merge ALU
  input  logic                                                   push_i,
  input  masku_insn_pkg::vid_t                                   id_i,
  input  masku_lane_pkg::vaddr_t                                 addr_i,
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    wdata_i,
  input  masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0]    be_i,
  // Status towards the issue controller
  output logic                                                   full_o,
  output logic                                                   retire_o,
  // Per-lane register file write port
  output masku_lane_pkg::lane_bits_t                             result_req_o,
  output masku_insn_pkg::vid_t  [masku_lane_pkg::NrLanes-1:0]    result_id_o,
  output masku_lane_pkg::vaddr_t [masku_lane_pkg::NrLanes-1:0]   result_addr_o,
  output masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    result_wdata_o,
  output masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0]    result_be_o,
  input  masku_lane_pkg::lane_bits_t                             result_gnt_i
);

  // Entry payload, shared by all lanes except data and strobes
  masku_insn_pkg::vid_t   id_q    [masku_lane_pkg::ResultQueueDepth];
  masku_lane_pkg::vaddr_t addr_q  [masku_lane_pkg::ResultQueueDepth];
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] wdata_q [masku_lane_pkg::ResultQueueDepth];
  masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0] be_q    [masku_lane_pkg::ResultQueueDepth];

  // Lanes of each slot still waiting for their grant
  masku_lane_pkg::lane_bits_t [masku_lane_pkg::ResultQueueDepth-1:0] pend_q;

  // Circular buffer pointers and occupancy
  logic [$clog2(masku_lane_pkg::ResultQueueDepth)-1:0]   wr_ptr_q;
  logic [$clog2(masku_lane_pkg::ResultQueueDepth)-1:0]   rd_ptr_q;
  logic [$clog2(masku_lane_pkg::ResultQueueDepth+1)-1:0] cnt_q;

  // Lanes of the oldest entry left after this cycle's grants
  masku_lane_pkg::lane_bits_t pend_left;

  assign pend_left = pend_q[rd_ptr_q] & ~result_gnt_i;

  // Oldest entry leaves when its last lane is granted
  assign retire_o = (cnt_q != '0) && (pend_left == '0);
  assign full_o   = (cnt_q == masku_lane_pkg::ResultQueueDepth);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q   <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      pend_q[rd_ptr_q] <= pend_left;
      // Push never hits a slot with pending lanes, so it may override
      if (push_i) begin
        pend_q[wr_ptr_q] <= '1;
        if (wr_ptr_q == masku_lane_pkg::ResultQueueDepth - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (retire_o) begin
        if (rd_ptr_q == masku_lane_pkg::ResultQueueDepth - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Occupancy follows push and retire
      case ({push_i, retire_o})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[wr_ptr_q]    <= id_i;
      addr_q[wr_ptr_q]  <= addr_i;
      wdata_q[wr_ptr_q] <= wdata_i;
      be_q[wr_ptr_q]    <= be_i;
    end
  end

  // Oldest entry drives every lane, requests drop lane by lane
  assign result_req_o = pend_q[rd_ptr_q];

  for (genvar l = 0; l < masku_lane_pkg::NrLanes; l++) begin : gen_lane_out
    assign result_id_o[l]    = id_q[rd_ptr_q];
    assign result_addr_o[l]  = addr_q[rd_ptr_q];
    assign result_wdata_o[l] = wdata_q[rd_ptr_q][l];
    assign result_be_o[l]    = be_q[rd_ptr_q][l];
  end

endmodule

//--- rtl/masku_top.sv
`timescale 1ns/1ps

module masku_top (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  // Instruction from the sequencer
  input  masku_insn_pkg::vid_t                                   pe_req_id_i,
  input  masku_lane_pkg::vaddr_t                                 pe_req_vd_i,
  input  masku_insn_pkg::vlen_t                                  pe_req_vl_i,
  input  logic                                                   pe_req_vm_i,
  input  logic                                                   pe_req_valid_i,
  output logic                                                   pe_req_ready_o,
  // Operands a, b and m from the lanes
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    operand_a_i,
  input  masku_lane_pkg::lane_bits_t                             operand_a_valid_i,
  output masku_lane_pkg::lane_bits_t                             operand_a_ready_o,
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    operand_b_i,
  input  masku_lane_pkg::lane_bits_t                             operand_b_valid_i,
  output masku_lane_pkg::lane_bits_t                             operand_b_ready_o,
  input  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    operand_m_i,
  input  masku_lane_pkg::lane_bits_t                             operand_m_valid_i,
  output masku_lane_pkg::lane_bits_t                             operand_m_ready_o,
  // Results towards the lane register files
  output masku_lane_pkg::lane_bits_t                             result_req_o,
  output masku_insn_pkg::vid_t  [masku_lane_pkg::NrLanes-1:0]    result_id_o,
  output masku_lane_pkg::vaddr_t [masku_lane_pkg::NrLanes-1:0]   result_addr_o,
  output masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0]    result_wdata_o,
  output masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0]    result_be_o,
  input  masku_lane_pkg::lane_bits_t                             result_gnt_i,
  // Completion towards the sequencer
  output masku_insn_pkg::insn_done_t                             vinsn_done_o
);

  // Beat control from the issue controller
  logic                   beat_fire;
  masku_lane_pkg::vaddr_t beat_idx;
  masku_lane_pkg::vaddr_t vd;
  logic                   vm;
  masku_insn_pkg::vlen_t  vl;
  masku_insn_pkg::vid_t   id;

  // Merged beat into the result queue
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] wdata;
  masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0] be;
  masku_lane_pkg::vaddr_t                              addr;

  // Queue status back to the controller
  logic queue_full;
  logic retire;

  masku_issue_ctrl masku_issue_ctrl_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .pe_req_id_i       (pe_req_id_i),
    .pe_req_vd_i       (pe_req_vd_i),
    .pe_req_vl_i       (pe_req_vl_i),
    .pe_req_vm_i       (pe_req_vm_i),
    .pe_req_valid_i    (pe_req_valid_i),
    .pe_req_ready_o    (pe_req_ready_o),
    .operand_a_valid_i (operand_a_valid_i),
    .operand_b_valid_i (operand_b_valid_i),
    .operand_m_valid_i (operand_m_valid_i),
    .operand_a_ready_o (operand_a_ready_o),
    .operand_b_ready_o (operand_b_ready_o),
    .operand_m_ready_o (operand_m_ready_o),
    .queue_full_i      (queue_full),
    .retire_i          (retire),
    .beat_fire_o       (beat_fire),
    .beat_idx_o        (beat_idx),
    .vd_o              (vd),
    .vm_o              (vm),
    .vl_o              (vl),
    .id_o              (id),
    .vinsn_done_o      (vinsn_done_o)
  );

  masku_merge_alu masku_merge_alu_i (
    .vd_i        (vd),
    .vm_i        (vm),
    .vl_i        (vl),
    .beat_idx_i  (beat_idx),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_m_i (operand_m_i),
    .wdata_o     (wdata),
    .be_o        (be),
    .addr_o      (addr)
  );

  masku_result_queue masku_result_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (beat_fire),
    .id_i           (id),
    .addr_i         (addr),
    .wdata_i        (wdata),
    .be_i           (be),
    .full_o         (queue_full),
    .retire_o       (retire),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

//--- tb/masku_ref.svh
`ifndef MASKU_REF_SVH
`define MASKU_REF_SVH

// Expected result of one lane in one beat
// Packed as {wdata, be, addr}, 64 + 8 + 8 bits
function automatic logic [79:0] expected_lane_result(
  input logic [63:0] a,
  input logic [63:0] b,
  input logic [63:0] m,
  input int unsigned vl,
  input logic        vm,
  input logic [7:0]  vd,
  input int unsigned k,
  input int unsigned l
);
  logic [63:0]  wdata;
  logic [7:0]   be;
  logic [7:0]   addr;
  int unsigned  base;
  // Global index of bit 0 of this lane in this beat
  base = k * 256 + l * 64;
  for (int unsigned j = 0; j < 64; j++) begin
    // Body bits with the mask set take the ALU result
    if ((base + j < vl) && (vm || m[j])) begin
      wdata[j] = a[j];
    end else begin
      wdata[j] = b[j];
    end
  end
  // Byte strobe follows vl only, the mask plays no part
  for (int unsigned n = 0; n < 8; n++) begin
    be[n] = (base + 8 * n) < vl;
  end
  addr = vd + 8'(k);
  return {wdata, be, addr};
endfunction

`endif

//--- tb/tb_masku.sv
`timescale 1ns/1ps

module tb_masku;

  logic                                                clk_i;
  logic                                                rst_ni;
  masku_insn_pkg::vid_t                                pe_req_id_i;
  masku_lane_pkg::vaddr_t                              pe_req_vd_i;
  masku_insn_pkg::vlen_t                               pe_req_vl_i;
  logic                                                pe_req_vm_i;
  logic                                                pe_req_valid_i;
  logic                                                pe_req_ready_o;
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] operand_a_i;
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] operand_b_i;
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] operand_m_i;
  masku_lane_pkg::lane_bits_t                          operand_a_valid_i;
  masku_lane_pkg::lane_bits_t                          operand_b_valid_i;
  masku_lane_pkg::lane_bits_t                          operand_m_valid_i;
  masku_lane_pkg::lane_bits_t                          operand_a_ready_o;
  masku_lane_pkg::lane_bits_t                          operand_b_ready_o;
  masku_lane_pkg::lane_bits_t                          operand_m_ready_o;
  masku_lane_pkg::lane_bits_t                          result_req_o;
  masku_insn_pkg::vid_t  [masku_lane_pkg::NrLanes-1:0] result_id_o;
  masku_lane_pkg::vaddr_t [masku_lane_pkg::NrLanes-1:0] result_addr_o;
  masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] result_wdata_o;
  masku_lane_pkg::strb_t [masku_lane_pkg::NrLanes-1:0] result_be_o;
  masku_lane_pkg::lane_bits_t                          result_gnt_i;
  masku_insn_pkg::insn_done_t                          vinsn_done_o;

  // Expected beats per lane, {id, wdata, be, addr}
  logic [82:0] exp_q [masku_lane_pkg::NrLanes][$];
  // Instruction state seen by the monitors
  logic        cur_vm;
  logic        insn_busy;
  logic        gnt_random;

  `include "masku_ref.svh"

  masku_top masku_top_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // Each lane drops its valid one cycle in eight
  function automatic masku_lane_pkg::lane_bits_t random_valid();
    masku_lane_pkg::lane_bits_t v;
    for (int l = 0; l < masku_lane_pkg::NrLanes; l++) begin
      v[l] = ($urandom % 8) != 0;
    end
    return v;
  endfunction

  // Register file grants, always on or random per lane
  always @(posedge clk_i) begin
    if (gnt_random) begin
      result_gnt_i <= masku_lane_pkg::lane_bits_t'($urandom);
    end else begin
      result_gnt_i <= '1;
    end
  end

  // Operand handshake rules, sampled mid-cycle
  always @(negedge clk_i) begin
    if (rst_ni) begin
      check_value("operand_b_ready_o", operand_a_ready_o, operand_b_ready_o);
      check_value("operand_m_ready_o", cur_vm ? '0 : operand_a_ready_o, operand_m_ready_o);
      if (operand_a_ready_o != '0) begin
        check_value("operand_a_ready_o", {masku_lane_pkg::NrLanes{1'b1}}, operand_a_ready_o);
        check_value("operand_a_valid_i", {masku_lane_pkg::NrLanes{1'b1}}, operand_a_valid_i);
        check_value("operand_b_valid_i", {masku_lane_pkg::NrLanes{1'b1}}, operand_b_valid_i);
        if (!cur_vm) begin
          check_value("operand_m_valid_i", {masku_lane_pkg::NrLanes{1'b1}}, operand_m_valid_i);
        end
      end
      // No new instruction while one is in flight
      if (insn_busy && vinsn_done_o == '0) begin
        check_value("pe_req_ready_o", 0, pe_req_ready_o);
      end
    end
  end

  // Scoreboard, every granted lane against its oldest expected beat
  always @(negedge clk_i) begin
    logic [82:0] head;
    for (int l = 0; l < masku_lane_pkg::NrLanes; l++) begin
      if (rst_ni && result_req_o[l] && result_gnt_i[l]) begin
        if (exp_q[l].size() == 0) begin
          fail_run($sformatf("lane %0d was granted a beat that was never issued", l));
        end else begin
          head = exp_q[l].pop_front();
          check_value($sformatf("result_id_o[%0d]", l), head[82:80], result_id_o[l]);
          check_value($sformatf("result_wdata_o[%0d]", l), head[79:16], result_wdata_o[l]);
          check_value($sformatf("result_be_o[%0d]", l), head[15:8], result_be_o[l]);
          check_value($sformatf("result_addr_o[%0d]", l), head[7:0], result_addr_o[l]);
        end
      end
    end
  end

  // One instruction from request to done pulse
  task automatic run_insn(input masku_insn_pkg::vid_t id, input masku_lane_pkg::vaddr_t vd,
                          input int unsigned vl, input logic vm, input logic gaps);
    masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] a;
    masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] b;
    masku_lane_pkg::elen_t [masku_lane_pkg::NrLanes-1:0] m;
    int unsigned nr_beats;
    int unsigned wait_cnt;
    logic        fired;
    nr_beats = (vl + 255) / 256;
    @(posedge clk_i);
    pe_req_id_i    <= id;
    pe_req_vd_i    <= vd;
    pe_req_vl_i    <= masku_insn_pkg::vlen_t'(vl);
    pe_req_vm_i    <= vm;
    pe_req_valid_i <= 1'b1;
    wait_cnt = 0;
    do begin
      @(negedge clk_i);
      wait_cnt++;
    end while (!pe_req_ready_o && wait_cnt < 100);
    if (!pe_req_ready_o) fail_run("instruction was never accepted");
    // Handshake completes on this edge
    @(posedge clk_i);
    pe_req_valid_i <= 1'b0;
    cur_vm    = vm;
    insn_busy = 1'b1;
    for (int unsigned k = 0; k < nr_beats; k++) begin
      for (int l = 0; l < masku_lane_pkg::NrLanes; l++) begin
        a[l] = {$urandom, $urandom};
        b[l] = {$urandom, $urandom};
        m[l] = {$urandom, $urandom};
      end
      operand_a_i <= a;
      operand_b_i <= b;
      operand_m_i <= m;
      wait_cnt = 0;
      do begin
        operand_a_valid_i <= gaps ? random_valid() : '1;
        operand_b_valid_i <= gaps ? random_valid() : '1;
        // Unmasked work must not wait for the mask
        operand_m_valid_i <= vm ? '0 : (gaps ? random_valid() : '1);
        @(negedge clk_i);
        fired = operand_a_ready_o[0];
        // No done while beats are still issuing
        check_value("vinsn_done_o", 0, vinsn_done_o);
        wait_cnt++;
        @(posedge clk_i);
      end while (!fired && wait_cnt < 200);
      if (!fired) fail_run($sformatf("beat %0d was never taken from the lanes", k));
      for (int l = 0; l < masku_lane_pkg::NrLanes; l++) begin
        exp_q[l].push_back({id, expected_lane_result(a[l], b[l], m[l], vl, vm, vd, k, l)});
      end
    end
    operand_a_valid_i <= '0;
    operand_b_valid_i <= '0;
    operand_m_valid_i <= '0;
    wait_cnt = 0;
    do begin
      @(negedge clk_i);
      wait_cnt++;
    end while (vinsn_done_o == '0 && wait_cnt < 500);
    if (vinsn_done_o == '0) fail_run("instruction never reported done");
    check_value("vinsn_done_o", masku_insn_pkg::insn_done_t'(1) << id, vinsn_done_o);
    check_value("pe_req_ready_o", 1, pe_req_ready_o);
    // Done only after every lane wrote its last beat
    for (int l = 0; l < masku_lane_pkg::NrLanes; l++) begin
      if (exp_q[l].size() != 0) fail_run($sformatf("done came before lane %0d finished", l));
    end
    insn_busy = 1'b0;
    @(negedge clk_i);
    check_value("vinsn_done_o", 0, vinsn_done_o);
  endtask

  initial begin
    void'($urandom(7));
    rst_ni            = 1'b0;
    pe_req_id_i       = '0;
    pe_req_vd_i       = '0;
    pe_req_vl_i       = '0;
    pe_req_vm_i       = 1'b1;
    pe_req_valid_i    = 1'b0;
    operand_a_i       = '0;
    operand_b_i       = '0;
    operand_m_i       = '0;
    operand_a_valid_i = '0;
    operand_b_valid_i = '0;
    operand_m_valid_i = '0;
    result_gnt_i      = '0;
    cur_vm            = 1'b1;
    insn_busy         = 1'b0;
    gnt_random        = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // Idle outputs right after reset
    @(negedge clk_i);
    check_value("pe_req_ready_o", 1, pe_req_ready_o);
    check_value("result_req_o", 0, result_req_o);
    check_value("operand_a_ready_o", 0, operand_a_ready_o);
    check_value("vinsn_done_o", 0, vinsn_done_o);
    // Unmasked single beat, then masked over three beats
    run_insn(3'd1, 8'h10, 100, 1'b1, 1'b0);
    run_insn(3'd2, 8'h20, 700, 1'b0, 1'b0);
    // Back-pressure from grants and gaps in the operands
    gnt_random = 1'b1;
    run_insn(3'd5, 8'h40, 2048, 1'b0, 1'b1);
    // Second unmasked instruction, address wraps at the top
    run_insn(3'd6, 8'hff, 300, 1'b1, 1'b1);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+tb
rtl/masku_lane_pkg.sv
rtl/masku_insn_pkg.sv
rtl/masku_merge_alu.sv
rtl/masku_issue_ctrl.sv
rtl/masku_result_queue.sv
rtl/masku_top.sv
tb/tb_masku.sv

//--- Makefile
TOP = tb_masku
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir $(OBJ) -o $(TOP)

# A $fatal in the testbench gives a non-zero exit status
run: compile
	./$(OBJ)/$(TOP)

clean:
	rm -rf $(OBJ)
